// ==== hw/credit_gate.sv ====
`timescale 1ns/1ps

module credit_gate (
	input  logic clk,
	input  logic rst,
	input  logic ray_valid,
	input  logic credit_return,
	output logic ray_ready,
	output logic accept
);

	import ray_pkg::*;

	logic [CREDIT_W-1:0] credit_cnt; // free result slots downstream

	assign ray_ready = (credit_cnt != '0);
	assign accept    = ray_valid & ray_ready;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			credit_cnt <= CREDIT_W'(CREDITS);
		end else begin
			case ({accept, credit_return})
				2'b10: credit_cnt <= credit_cnt - 1'b1; // ray taken
				2'b01: credit_cnt <= credit_cnt + 1'b1; // slot freed
				default: credit_cnt <= credit_cnt; // none or both
			endcase
		end
	end

endmodule

// ==== hw/interval_merge.sv ====
`timescale 1ns/1ps

module interval_merge (
	input  logic           clk,
	input  logic           rst,
	input  ray_pkg::dist_t tmin_x,
	input  ray_pkg::dist_t tmin_y,
	input  ray_pkg::dist_t tmin_z,
	input  ray_pkg::dist_t tmax_x,
	input  ray_pkg::dist_t tmax_y,
	input  ray_pkg::dist_t tmax_z,
	input  logic           reject_x,
	input  logic           reject_y,
	input  logic           reject_z,
	output logic           hit
);

	import ray_pkg::*;

	dist_t tnear_n;
	dist_t tfar_n;
	dist_t tnear_r;
	dist_t tfar_r;
	logic  rej_r;

	// latest entry over the three slabs
	always_comb begin
		tnear_n = tmin_x;
		if (tmin_y > tnear_n)
			tnear_n = tmin_y;
		if (tmin_z > tnear_n)
			tnear_n = tmin_z;
	end

	// earliest exit
	always_comb begin
		tfar_n = tmax_x;
		if (tmax_y < tfar_n)
			tfar_n = tmax_y;
		if (tmax_z < tfar_n)
			tfar_n = tmax_z;
	end

	always_ff @(posedge clk) begin
		tnear_r <= tnear_n;
		tfar_r  <= tfar_n;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rej_r <= 1'b0;
			hit   <= 1'b0;
		end else begin
			rej_r <= reject_x | reject_y | reject_z;
			hit   <= !rej_r && (tfar_r >= tnear_r) && (tfar_r > 0); // box ahead of origin
		end
	end

endmodule

// ==== hw/pipe_delay.sv ====
`timescale 1ns/1ps

module pipe_delay #(
	parameter type payload_t = logic,
	parameter int DEPTH = 1
) (
	input  logic     clk,
	input  logic     rst,
	input  payload_t d,
	output payload_t q
);

	payload_t stages [DEPTH]; // stages[0] takes d

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				stages[i] <= '0;
			end
		end else begin
			stages[0] <= d;
			for (int i = 1; i < DEPTH; i++) begin
				stages[i] <= stages[i-1];
			end
		end
	end

	assign q = stages[DEPTH-1]; // oldest entry

endmodule

// ==== hw/ray_aabb_top.sv ====
`timescale 1ns/1ps

module ray_aabb_top (
	input  logic            clk,
	input  logic            rst,
	input  logic            ray_valid,
	output logic            ray_ready,
	input  ray_pkg::tag_t   ray_tag,
	input  ray_pkg::coord_t org_x,
	input  ray_pkg::coord_t org_y,
	input  ray_pkg::coord_t org_z,
	input  ray_pkg::coord_t lo_x,
	input  ray_pkg::coord_t lo_y,
	input  ray_pkg::coord_t lo_z,
	input  ray_pkg::coord_t hi_x,
	input  ray_pkg::coord_t hi_y,
	input  ray_pkg::coord_t hi_z,
	input  ray_pkg::recip_t inv_x,
	input  ray_pkg::recip_t inv_y,
	input  ray_pkg::recip_t inv_z,
	input  logic            par_x,
	input  logic            par_y,
	input  logic            par_z,
	output logic            hit_valid,
	output logic            hit,
	output ray_pkg::tag_t   hit_tag,
	input  logic            credit_return
);

	import ray_pkg::*;

	logic  accept;
	dist_t tmin_x;
	dist_t tmin_y;
	dist_t tmin_z;
	dist_t tmax_x;
	dist_t tmax_y;
	dist_t tmax_z;
	logic  reject_x;
	logic  reject_y;
	logic  reject_z;

	//////////////////////////////////////////////////////////////////////
	// admission
	//////////////////////////////////////////////////////////////////////

	credit_gate gate_i (
		.clk          (clk),
		.rst          (rst),
		.ray_valid    (ray_valid),
		.credit_return(credit_return),
		.ray_ready    (ray_ready),
		.accept       (accept)
	);

	//////////////////////////////////////////////////////////////////////
	// arithmetic pipeline, advances every cycle
	//////////////////////////////////////////////////////////////////////

	slab_axis slab_x_i (
		.clk(clk), .rst(rst),
		.org(org_x), .lo(lo_x), .hi(hi_x), .inv(inv_x), .par(par_x),
		.tmin(tmin_x), .tmax(tmax_x), .reject(reject_x)
	);

	slab_axis slab_y_i (
		.clk(clk), .rst(rst),
		.org(org_y), .lo(lo_y), .hi(hi_y), .inv(inv_y), .par(par_y),
		.tmin(tmin_y), .tmax(tmax_y), .reject(reject_y)
	);

	slab_axis slab_z_i (
		.clk(clk), .rst(rst),
		.org(org_z), .lo(lo_z), .hi(hi_z), .inv(inv_z), .par(par_z),
		.tmin(tmin_z), .tmax(tmax_z), .reject(reject_z)
	);

	interval_merge merge_i (
		.clk     (clk),
		.rst     (rst),
		.tmin_x  (tmin_x),
		.tmin_y  (tmin_y),
		.tmin_z  (tmin_z),
		.tmax_x  (tmax_x),
		.tmax_y  (tmax_y),
		.tmax_z  (tmax_z),
		.reject_x(reject_x),
		.reject_y(reject_y),
		.reject_z(reject_z),
		.hit     (hit)
	);

	// valid and tag ride alongside the math
	pipe_delay #(.payload_t(logic), .DEPTH(PIPE_LAT)) valid_dly_i (
		.clk(clk),
		.rst(rst),
		.d  (accept),
		.q  (hit_valid)
	);

	pipe_delay #(.payload_t(tag_t), .DEPTH(PIPE_LAT)) tag_dly_i (
		.clk(clk),
		.rst(rst),
		.d  (ray_tag),
		.q  (hit_tag)
	);

endmodule

// ==== hw/ray_pkg.sv ====
package ray_pkg;

	//////////////////////////////////////////////////////////////////////
	// number formats
	//////////////////////////////////////////////////////////////////////

	typedef logic signed [15:0] coord_t; // origin and box bounds
	typedef logic signed [15:0] recip_t; // 1/dir, RECIP_FRAC fraction bits
	typedef logic signed [16:0] diff_t; // bound minus origin
	typedef logic signed [32:0] dist_t; // full diff_t * recip_t product
	typedef logic [7:0] tag_t; // ray id

	localparam int RECIP_FRAC = 12;

	// open interval used for an axis the ray runs parallel to
	localparam dist_t DIST_MAX = {1'b0, {32{1'b1}}};
	localparam dist_t DIST_MIN = {1'b1, {32{1'b0}}};

	//////////////////////////////////////////////////////////////////////
	// pipeline and flow control
	//////////////////////////////////////////////////////////////////////

	localparam int SLAB_LAT = 2; // slab_axis register stages
	localparam int MERGE_LAT = 2; // interval_merge register stages
	localparam int PIPE_LAT = SLAB_LAT + MERGE_LAT;

	localparam int CREDITS = 4; // result slots at the consumer
	localparam int CREDIT_W = $clog2(CREDITS + 1); // holds 0..CREDITS

endpackage

// ==== hw/slab_axis.sv ====
`timescale 1ns/1ps

module slab_axis (
	input  logic            clk,
	input  logic            rst,
	input  ray_pkg::coord_t org,
	input  ray_pkg::coord_t lo,
	input  ray_pkg::coord_t hi,
	input  ray_pkg::recip_t inv,
	input  logic            par,
	output ray_pkg::dist_t  tmin,
	output ray_pkg::dist_t  tmax,
	output logic            reject
);

	import ray_pkg::*;

	diff_t  d_lo_r; // lo - org
	diff_t  d_hi_r; // hi - org
	recip_t inv_r;
	logic   neg_r; // direction points down the axis
	logic   par_r;
	logic   inside_r; // origin between the two planes

	dist_t  p_lo;
	dist_t  p_hi;

	//////////////////////////////////////////////////////////////////////
	// stage 1: offsets from the origin
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		d_lo_r <= diff_t'(lo) - diff_t'(org);
		d_hi_r <= diff_t'(hi) - diff_t'(org);
		inv_r  <= inv;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			neg_r    <= 1'b0;
			par_r    <= 1'b0;
			inside_r <= 1'b0;
		end else begin
			neg_r    <= inv[$bits(recip_t)-1];
			par_r    <= par;
			inside_r <= (org >= lo) && (org <= hi);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stage 2: scale by 1/dir and order entry before exit
	//////////////////////////////////////////////////////////////////////

	assign p_lo = dist_t'(d_lo_r) * dist_t'(inv_r); // exact, fits 33 bits
	assign p_hi = dist_t'(d_hi_r) * dist_t'(inv_r);

	always_ff @(posedge clk) begin
		if (par_r) begin
			tmin <= DIST_MIN; // axis places no bound on t
			tmax <= DIST_MAX;
		end else if (neg_r) begin
			tmin <= p_hi; // hi plane reached first
			tmax <= p_lo;
		end else begin
			tmin <= p_lo;
			tmax <= p_hi;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			reject <= 1'b0;
		end else begin
			reject <= par_r && !inside_r; // parallel and outside the slab
		end
	end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module ray_aabb_tb -f verilog.f -o ray_aabb_sim

./obj_dir/ray_aabb_sim 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

// ==== test/ray_aabb_assert.sv ====
`timescale 1ns/1ps

module ray_aabb_assert (
	input logic                            clk,
	input logic                            rst,
	input logic                            accept,
	input logic                            credit_return,
	input logic [ray_pkg::CREDIT_W-1:0]    credit_cnt
);

	import ray_pkg::*;

	int taken; // rays admitted whose credit is still out

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			taken <= 0;
		end else begin
			taken <= taken + int'(accept) - int'(credit_return);
		end
	end

	count_bounded: assert property (@(posedge clk) disable iff (rst)
		credit_cnt <= CREDITS)
		else $error("credit count above the consumer buffer size");

	no_accept_empty: assert property (@(posedge clk) disable iff (rst)
		!(accept && taken >= CREDITS))
		else $error("ray accepted with every credit in use");

	no_spare_return: assert property (@(posedge clk) disable iff (rst)
		!(credit_return && credit_cnt == CREDITS))
		else $error("credit returned with no result outstanding");

endmodule

bind credit_gate ray_aabb_assert assert_i (
	.clk          (clk),
	.rst          (rst),
	.accept       (accept),
	.credit_return(credit_return),
	.credit_cnt   (credit_cnt)
);

// ==== test/ray_aabb_tb.sv ====
`timescale 1ns/1ps

module ray_aabb_tb;

	import ray_pkg::*;

	localparam int MAX_CYCLES = 2000; // directed rays plus ~400 cycles of streaming
	localparam logic [31:0] SEED = 32'hde3c_1310;

	logic    clk;
	logic    rst;
	logic    ray_valid;
	logic    ray_ready;
	tag_t    ray_tag;
	coord_t  org [3];
	coord_t  lo [3];
	coord_t  hi [3];
	recip_t  inv [3];
	logic    par [3];
	logic    hit_valid;
	logic    hit;
	tag_t    hit_tag;
	logic    credit_return;

	logic    exp_hit_q [$];
	tag_t    exp_tag_q [$];
	int      acc_cyc_q [$];
	int      cycle;
	int      accept_cnt;
	int      held; // results received whose credit is not yet returned
	int      ret_mode; // 0 hold, 1 immediate, 2 random delay
	int      ret_budget; // single returns allowed while holding
	tag_t    next_tag;
	string   test_name;
	logic [31:0] rng_state;
	logic [31:0] ret_state;

	ray_aabb_top dut_i (
		.clk(clk), .rst(rst),
		.ray_valid(ray_valid), .ray_ready(ray_ready), .ray_tag(ray_tag),
		.org_x(org[0]), .org_y(org[1]), .org_z(org[2]),
		.lo_x(lo[0]), .lo_y(lo[1]), .lo_z(lo[2]),
		.hi_x(hi[0]), .hi_y(hi[1]), .hi_z(hi[2]),
		.inv_x(inv[0]), .inv_y(inv[1]), .inv_z(inv[2]),
		.par_x(par[0]), .par_y(par[1]), .par_z(par[2]),
		.hit_valid(hit_valid), .hit(hit), .hit_tag(hit_tag),
		.credit_return(credit_return)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// slab method reference model on exact integers
	//////////////////////////////////////////////////////////////////////

	function automatic logic model_hit();
		longint tnear;
		longint tfar;
		longint t_lo;
		longint t_hi;
		logic   rej;
		tnear = -(64'sd1 <<< 40);
		tfar  = 64'sd1 <<< 40;
		rej   = 1'b0;
		for (int a = 0; a < 3; a++) begin
			if (par[a]) begin
				if (org[a] < lo[a] || org[a] > hi[a])
					rej = 1'b1; // parallel outside the slab never enters it
			end else begin
				t_lo = (longint'(lo[a]) - longint'(org[a])) * longint'(inv[a]);
				t_hi = (longint'(hi[a]) - longint'(org[a])) * longint'(inv[a]);
				if (inv[a] < 0) begin
					tnear = (t_hi > tnear) ? t_hi : tnear;
					tfar  = (t_lo < tfar) ? t_lo : tfar;
				end else begin
					tnear = (t_lo > tnear) ? t_lo : tnear;
					tfar  = (t_hi < tfar) ? t_hi : tfar;
				end
			end
		end
		return !rej && (tfar >= tnear) && (tfar > 0);
	endfunction

	task automatic stop_run();
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_val(input string what, input logic signed [63:0] expected,
			input logic signed [63:0] actual);
		if (expected !== actual) begin
			$display("** Error: %s, %s: expected %0d, actual %0d", test_name, what,
				expected, actual);
			stop_run();
		end
	endtask

	// records accepted rays and checks each result in order
	always @(posedge clk) begin : monitor
		logic exp_h;
		tag_t exp_t;
		int   acc_c;
		cycle++;
		if (cycle >= MAX_CYCLES) begin
			$display("timeout: run still busy after %0d cycles", cycle);
			stop_run();
		end else if (!rst) begin
			if (ray_valid && ray_ready) begin
				exp_hit_q.push_back(model_hit());
				exp_tag_q.push_back(ray_tag);
				acc_cyc_q.push_back(cycle);
				accept_cnt++;
			end
			if (hit_valid && exp_hit_q.size() == 0) begin
				$display("result with tag %0d arrived with no ray outstanding", hit_tag);
				stop_run();
			end else if (hit_valid) begin
				exp_h = exp_hit_q.pop_front();
				exp_t = exp_tag_q.pop_front();
				acc_c = acc_cyc_q.pop_front();
				check_val("hit_tag", exp_t, hit_tag);
				check_val("hit", exp_h, hit);
				check_val("latency", PIPE_LAT, cycle - acc_c);
				held++;
			end
		end
	end

	// consumer side credit return
	always @(posedge clk) begin : returner
		#1;
		credit_return = 1'b0;
		ret_state = xorshift(ret_state);
		if (!rst && held > 0) begin
			if (ret_mode == 1 || (ret_mode == 2 && ret_state[1:0] != 2'b00) ||
					(ret_mode == 0 && ret_budget > 0)) begin
				credit_return = 1'b1;
				held--;
				if (ret_mode == 0)
					ret_budget--;
			end
		end
	end

	task automatic send_ray();
		ray_valid = 1'b1;
		ray_tag   = next_tag;
		@(posedge clk);
		while (!ray_ready)
			@(posedge clk);
		#1;
		ray_valid = 1'b0;
		next_tag++;
	endtask

	task automatic wait_idle();
		while (exp_hit_q.size() != 0 || held != 0)
			@(posedge clk);
		#1;
	endtask

	// box is [0,10] on every axis
	task automatic shoot(input int ox, input int oy, input int oz, input int vx,
			input int vy, input int vz, input logic [2:0] p);
		org[0] = coord_t'(ox);
		org[1] = coord_t'(oy);
		org[2] = coord_t'(oz);
		inv[0] = recip_t'(vx);
		inv[1] = recip_t'(vy);
		inv[2] = recip_t'(vz);
		for (int a = 0; a < 3; a++) begin
			lo[a]  = coord_t'(0);
			hi[a]  = coord_t'(10);
			par[a] = p[a];
		end
		send_ray();
	endtask

	task automatic random_ray();
		logic [31:0] r;
		for (int a = 0; a < 3; a++) begin
			rng_state = xorshift(rng_state);
			r = rng_state;
			lo[a]  = coord_t'($signed(r[6:0]));
			hi[a]  = lo[a] + coord_t'(r[12:7]);
			org[a] = coord_t'($signed(r[21:13]));
			par[a] = (r[24:22] == 3'd0); // about one axis in eight
			rng_state = xorshift(rng_state);
			inv[a] = recip_t'(rng_state[15:0]);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic positive_rays();
		test_name = "positive";
		shoot(-100, -100, -100, 4096, 4096, 4096, 3'b000);
		shoot(-100, -95, -98, 4096, 4096, 4096, 3'b000);
		shoot(-100, -100, -50, 4096, 4096, 4096, 3'b000); // passes beside
		wait_idle();
	endtask

	task automatic negative_dirs();
		test_name = "negative";
		shoot(100, 100, 100, -4096, -4096, -4096, 3'b000);
		shoot(100, -100, 100, -4096, 4096, -4096, 3'b000);
		shoot(-100, -100, -100, -4096, -4096, -4096, 3'b000); // aimed away
		wait_idle();
	endtask

	task automatic parallel_flags();
		test_name = "parallel";
		shoot(5, -100, -100, 0, 4096, 4096, 3'b001);
		shoot(50, -100, -100, 0, 4096, 4096, 3'b001);
		shoot(5, 5, 5, 0, 0, 0, 3'b111);
		shoot(5, 5, 11, 0, 0, 0, 3'b111);
		wait_idle();
	endtask

	task automatic miss_cases();
		test_name = "miss";
		shoot(100, 100, 100, 4096, 4096, 4096, 3'b000); // box behind
		shoot(10, 10, 10, 4096, 4096, 4096, 3'b000); // touches at t = 0
		shoot(-100, -80, -100, 4096, 4096, 4096, 3'b000); // disjoint slabs
		wait_idle();
	endtask

	task automatic credit_flow();
		int acc0;
		test_name = "credits";
		ret_mode = 0;
		acc0 = accept_cnt;
		random_ray();
		ray_tag   = next_tag;
		ray_valid = 1'b1;
		repeat (CREDITS + 4) @(posedge clk);
		#1;
		check_val("accepted", CREDITS, accept_cnt - acc0);
		check_val("ray_ready", 0, ray_ready);
		ret_budget = 1;
		repeat (4) @(posedge clk);
		#1;
		check_val("accepted", CREDITS + 1, accept_cnt - acc0);
		check_val("ray_ready", 0, ray_ready);
		ray_valid = 1'b0;
		next_tag++;
		ret_mode = 1;
		wait_idle();
	endtask

	task automatic random_stream();
		test_name = "stream";
		ret_mode = 2;
		for (int i = 0; i < 200; i++) begin
			random_ray();
			send_ray();
		end
		wait_idle();
	endtask

	initial begin
		rst           = 1'b1;
		ray_valid     = 1'b0;
		ray_tag       = '0;
		credit_return = 1'b0;
		for (int a = 0; a < 3; a++) begin
			org[a] = '0;
			lo[a]  = '0;
			hi[a]  = '0;
			inv[a] = '0;
			par[a] = 1'b0;
		end
		cycle      = 0;
		accept_cnt = 0;
		held       = 0;
		ret_mode   = 1;
		ret_budget = 0;
		next_tag   = '0;
		test_name  = "reset";
		rng_state  = SEED;
		ret_state  = xorshift(SEED);
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		@(posedge clk);
		#1;
		check_val("ray_ready", 1, ray_ready);
		positive_rays();
		negative_dirs();
		parallel_flags();
		miss_cases();
		credit_flow();
		random_stream();
		$display("TEST OK");
		$finish;
	end

endmodule

// ==== verilog.f ====
hw/ray_pkg.sv
hw/pipe_delay.sv
hw/slab_axis.sv
hw/interval_merge.sv
hw/credit_gate.sv
hw/ray_aabb_top.sv
test/ray_aabb_assert.sv
test/ray_aabb_tb.sv
